// File: project.f
+incdir+design
design/vram_pkg.sv
design/xvga_timing.sv
design/video_scanout.sv
design/bar_pattern_writer.sv
design/zbt_port.sv
design/zbt_video_top.sv
bench/zbt_sram_model.sv
bench/tb_zbt_video.sv

// File: run_sim.sh
#!/bin/sh
# builds the zbt video testbench with verilator and runs it
# the exit status is the simulator's own status

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_zbt_video \
   -Mdir obj_dir \
   -o sim_tb_zbt_video \
   -f project.f
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/sim_tb_zbt_video
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation failed with status $status"
fi
exit "$status"

// File: bench/tb_zbt_video.sv
////////////////////////////////////////
// testbench for the zbt frame buffer video top
////////////////////////////////////////
`timescale 1ns/1ps
`include "xvga_defs.svh"

module tb_zbt_video;
   import vram_pkg::*;

   // the run covers four frames with a few lines of margin on top
   localparam int FRAME_CYCLES   = `H_TOTAL * `V_TOTAL;
   localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES + 64 * `H_TOTAL;

   logic                    clk;
   logic                    rst_n;
   logic                    bar_period;
   logic                    hw_bars;
   logic [`VRAM_DATA_W-1:0] ram_rdata;
   pixel_t                  pixel;
   logic                    hsync_out;
   logic                    vsync_out;
   logic                    blank_out;
   logic [`VRAM_ADDR_W-1:0] ram_address;
   logic                    ram_we_b;
   logic                    ram_cen_b;
   logic [`VRAM_DATA_W-1:0] ram_wdata;
   logic                    ram_data_oe;

   // memory image rebuilt from the pins
   logic [`VRAM_DATA_W-1:0] image [0:(1 << `VRAM_ADDR_W) - 1];
   bit                      written [0:(1 << `VRAM_ADDR_W) - 1];

   // raster position of this cycle and of the one before
   int pos_h = 0;
   int pos_v = 0;
   int prev_h = 0;
   int prev_v = 0;
   bit prev_ok = 1'b0;
   bit hw_prev = 1'b0;
   bit bp_prev = 1'b0;
   // writes seen on the address pins one and two cycles back
   bit                      wp1 = 1'b0;
   bit                      wp2 = 1'b0;
   bit                      wb1 = 1'b0;
   bit                      wb2 = 1'b0;
   logic [`VRAM_ADDR_W-1:0] wa1;
   logic [`VRAM_ADDR_W-1:0] wa2;
   // expected values
   logic                    exp_blank;
   logic                    exp_hs;
   logic                    exp_vs;
   logic [`VRAM_DATA_W-1:0] exp_word;
   pixel_t                  exp_pixel;
   logic [`VRAM_ADDR_W-1:0] pix_addr;
   logic [`VRAM_ADDR_W-1:0] exp_addr;
   int ahead_h;
   int ahead_v;
   int cycles = 0;
   int n_writes = 0;
   int n_pixels = 0;
   int n_bars = 0;

   zbt_video_top dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .bar_period  (bar_period),
      .hw_bars     (hw_bars),
      .ram_rdata   (ram_rdata),
      .pixel       (pixel),
      .hsync_out   (hsync_out),
      .vsync_out   (vsync_out),
      .blank_out   (blank_out),
      .ram_address (ram_address),
      .ram_we_b    (ram_we_b),
      .ram_cen_b   (ram_cen_b),
      .ram_wdata   (ram_wdata),
      .ram_data_oe (ram_data_oe)
   );

   zbt_sram_model sram (
      .clk     (clk),
      .address (ram_address),
      .we_b    (ram_we_b),
      .cen_b   (ram_cen_b),
      .wdata   (ram_wdata),
      .data_oe (ram_data_oe),
      .rdata   (ram_rdata)
   );

   // 40 ns pixel clock
   initial clk = 1'b0;
   always #20 clk = ~clk;

   // bar word for an address
   // narrow bars take bits 6..3 and wide bars 7..4
   function automatic logic [`VRAM_DATA_W-1:0] bar_word(input logic [`VRAM_ADDR_W-1:0] addr,
                                                         input logic narrow);
      logic [3:0] field;
      field = narrow ? addr[6:3] : addr[7:4];
      return {4'h0, {4{field, 4'h0}}};
   endfunction

   task automatic stop_with_failure();
      $display("TB FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic report_mismatch(input string name, input logic [35:0] expected,
                                  input logic [35:0] actual);
      $display("CHECK FAILED %s: expected %0h, got %0h at %0t", name, expected, actual, $time);
      stop_with_failure();
   endtask

   task automatic report_problem(input string why);
      $display("ERROR: %s", why);
      stop_with_failure();
   endtask

   // frame marker 2 ns after the edge that drops vsync
   task automatic next_vsync();
      @(negedge vsync_out);
      #2;
   endtask

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////
   initial begin
      rst_n      = 1'b0;
      bar_period = 1'b0;
      hw_bars    = 1'b0;
      repeat (8) @(posedge clk);
      #2 rst_n = 1'b1;
      // narrow bars from the first visible line of the second frame
      next_vsync();
      @(negedge blank_out);
      #2 bar_period = 1'b1;
      // hardware bars over the fourth frame
      next_vsync();
      next_vsync();
      hw_bars = 1'b1;
      next_vsync();
      if (n_writes > 0 && n_pixels > 0 && n_bars > 0) begin
         $display("TB PASSED");
         $finish;
      end else begin
         report_problem($sformatf("checks never reached: %0d writes, %0d pixels, %0d bars",
                                  n_writes, n_pixels, n_bars));
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         report_problem($sformatf("timeout, frame markers missing after %0d cycles", cycles));
      end
   end

   ////////////////////////////////////////
   // monitor sampled on the falling edge
   ////////////////////////////////////////
   always @(negedge clk) begin
      if (!rst_n) begin
         // pins idle and syncs inactive in reset
         assert (ram_we_b === 1'b1)
            else report_mismatch("ram_we_b", 36'(1'b1), 36'(ram_we_b));
         assert (ram_data_oe === 1'b0)
            else report_mismatch("ram_data_oe", 36'(1'b0), 36'(ram_data_oe));
         assert (hsync_out === 1'b1)
            else report_mismatch("hsync_out", 36'(1'b1), 36'(hsync_out));
         assert (vsync_out === 1'b1)
            else report_mismatch("vsync_out", 36'(1'b1), 36'(vsync_out));
      end else begin
         if (prev_ok) begin
            // outputs belong to the previous raster position
            exp_blank = (prev_h >= `H_ACTIVE) || (prev_v >= `V_ACTIVE);
            exp_hs    = !((prev_h >= `H_SYNC_ON) && (prev_h < `H_SYNC_OFF));
            exp_vs    = !((prev_v >= `V_SYNC_ON) && (prev_v < `V_SYNC_OFF));
            assert (blank_out === exp_blank)
               else report_mismatch("blank_out", 36'(exp_blank), 36'(blank_out));
            assert (hsync_out === exp_hs)
               else report_mismatch("hsync_out", 36'(exp_hs), 36'(hsync_out));
            assert (vsync_out === exp_vs)
               else report_mismatch("vsync_out", 36'(exp_vs), 36'(vsync_out));
            assert (ram_cen_b === 1'b0)
               else report_mismatch("ram_cen_b", 36'(1'b0), 36'(ram_cen_b));
            // a read on the pins fetches the word eight pixels past the last position
            if (ram_we_b === 1'b1) begin
               ahead_h = prev_h + `FETCH_AHEAD;
               ahead_v = prev_v;
               if (ahead_h >= `H_TOTAL) begin
                  ahead_h = ahead_h - `H_TOTAL;
                  ahead_v = (ahead_v == `V_TOTAL - 1) ? 0 : ahead_v + 1;
               end
               exp_addr = {1'b0, ahead_v[9:0], ahead_h[9:2]};
               assert (ram_address === exp_addr)
                  else report_mismatch("ram_address", 36'(exp_addr), 36'(ram_address));
            end
            if (hw_prev) begin
               exp_pixel = {prev_h[8:6], 5'b0};
               assert (pixel === exp_pixel)
                  else report_mismatch("pixel", 36'(exp_pixel), 36'(pixel));
               n_bars++;
            end else if (!exp_blank) begin
               pix_addr = {1'b0, prev_v[9:0], prev_h[9:2]};
               if (written[pix_addr]) begin
                  // first pixel of a group sits in the top byte
                  exp_word  = image[pix_addr];
                  exp_pixel = 8'(exp_word >> (8 * (3 - prev_h % 4)));
                  assert (pixel === exp_pixel)
                     else report_mismatch("pixel", 36'(exp_pixel), 36'(pixel));
                  n_pixels++;
               end
            end
         end
         // write data trails its address on the pins by two cycles
         assert (ram_data_oe === wp2)
            else report_mismatch("ram_data_oe", 36'(wp2), 36'(ram_data_oe));
         if (wp2) begin
            exp_word = bar_word(wa2, wb2);
            assert (ram_wdata === exp_word)
               else report_mismatch("ram_wdata", exp_word, ram_wdata);
            image[wa2]   = ram_wdata;
            written[wa2] = 1'b1;
            n_writes++;
         end
         // no write address over the visible area
         if (!ram_we_b) begin
            assert (blank_out === 1'b1)
               else report_problem("write address on the ram pins while blank_out is low");
         end
         wp2 = wp1;
         wa2 = wa1;
         wb2 = wb1;
         // address on the pins was issued a cycle ago under that cycle's bar_period
         wp1 = !ram_we_b;
         wa1 = ram_address;
         wb1 = bp_prev;
         bp_prev = bar_period;
         hw_prev = hw_bars;
         // step the reference raster
         prev_h  = pos_h;
         prev_v  = pos_v;
         prev_ok = 1'b1;
         if (pos_h == `H_TOTAL - 1) begin
            pos_h = 0;
            pos_v = (pos_v == `V_TOTAL - 1) ? 0 : pos_v + 1;
         end else begin
            pos_h = pos_h + 1;
         end
      end
   end

endmodule

// File: bench/zbt_sram_model.sv
////////////////////////////////////////
// behavioural pipelined zbt sram, two-cycle latency
////////////////////////////////////////
`timescale 1ns/1ps
`include "xvga_defs.svh"

module zbt_sram_model (
   input  logic                    clk,
   input  logic [`VRAM_ADDR_W-1:0] address,
   input  logic                    we_b,
   input  logic                    cen_b,
   input  logic [`VRAM_DATA_W-1:0] wdata,
   input  logic                    data_oe,
   output logic [`VRAM_DATA_W-1:0] rdata
);

   // 512k words of 36 bits
   logic [`VRAM_DATA_W-1:0] mem [0:(1 << `VRAM_ADDR_W) - 1];

   // address and command pipeline
   logic [`VRAM_ADDR_W-1:0] addr_d1;
   logic [`VRAM_ADDR_W-1:0] addr_d2;
   logic                    we_d1;
   logic                    we_d2;
   logic                    rd_d1;

   initial rdata = '0;

   always @(posedge clk) begin
      // late write, data sits on the bus two cycles after its address
      // committed before the read below so a read sees the newest word
      if (we_d2 && data_oe) begin
         mem[addr_d2] = wdata;
      end
      // read word two cycles after its address
      if (rd_d1) begin
         rdata <= mem[addr_d1];
      end
      addr_d2 <= addr_d1;
      we_d2   <= we_d1;
      addr_d1 <= address;
      we_d1   <= !cen_b && !we_b;
      rd_d1   <= !cen_b && we_b;
   end

endmodule

// File: design/zbt_video_top.sv
////////////////////////////////////////
// zbt frame buffer video top level
////////////////////////////////////////
`timescale 1ns/1ps
`include "xvga_defs.svh"

module zbt_video_top (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    bar_period,
   input  logic                    hw_bars,
   input  logic [`VRAM_DATA_W-1:0] ram_rdata,
   output vram_pkg::pixel_t        pixel,
   output logic                    hsync_out,
   output logic                    vsync_out,
   output logic                    blank_out,
   output logic [`VRAM_ADDR_W-1:0] ram_address,
   output logic                    ram_we_b,
   output logic                    ram_cen_b,
   output logic [`VRAM_DATA_W-1:0] ram_wdata,
   output logic                    ram_data_oe
);

   // raster
   logic [`HCOUNT_W-1:0]    hcount;
   logic [`VCOUNT_W-1:0]    vcount;
   logic                    hsync;
   logic                    vsync;
   logic                    blank;
   // read side of the port
   logic [`VRAM_ADDR_W-1:0] read_addr;
   logic                    read_req;
   logic [`VRAM_DATA_W-1:0] read_data;
   // write side of the port
   logic [`VRAM_ADDR_W-1:0] write_addr;
   logic [`VRAM_DATA_W-1:0] write_data;

   xvga_timing u_timing (
      .clk    (clk),
      .rst_n  (rst_n),
      .hcount (hcount),
      .vcount (vcount),
      .hsync  (hsync),
      .vsync  (vsync),
      .blank  (blank)
   );

   video_scanout u_scanout (
      .clk       (clk),
      .rst_n     (rst_n),
      .hcount    (hcount),
      .vcount    (vcount),
      .hsync     (hsync),
      .vsync     (vsync),
      .blank     (blank),
      .hw_bars   (hw_bars),
      .read_data (read_data),
      .read_addr (read_addr),
      .read_req  (read_req),
      .pixel     (pixel),
      .hsync_out (hsync_out),
      .vsync_out (vsync_out),
      .blank_out (blank_out)
   );

   bar_pattern_writer u_writer (
      .clk        (clk),
      .rst_n      (rst_n),
      .bar_period (bar_period),
      .write_addr (write_addr),
      .write_data (write_data)
   );

   zbt_port u_port (
      .clk         (clk),
      .rst_n       (rst_n),
      .read_req    (read_req),
      .read_addr   (read_addr),
      .write_addr  (write_addr),
      .write_data  (write_data),
      .read_data   (read_data),
      .ram_address (ram_address),
      .ram_we_b    (ram_we_b),
      .ram_cen_b   (ram_cen_b),
      .ram_wdata   (ram_wdata),
      .ram_data_oe (ram_data_oe),
      .ram_rdata   (ram_rdata)
   );

endmodule

// File: design/zbt_port.sv
////////////////////////////////////////
// zbt sram port sharing and pin pipeline
// reads win, writes take every idle slot
////////////////////////////////////////
`timescale 1ns/1ps
`include "xvga_defs.svh"

module zbt_port (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    read_req,
   input  logic [`VRAM_ADDR_W-1:0] read_addr,
   input  logic [`VRAM_ADDR_W-1:0] write_addr,
   input  logic [`VRAM_DATA_W-1:0] write_data,
   output logic [`VRAM_DATA_W-1:0] read_data,
   output logic [`VRAM_ADDR_W-1:0] ram_address,
   output logic                    ram_we_b,
   output logic                    ram_cen_b,
   output logic [`VRAM_DATA_W-1:0] ram_wdata,
   output logic                    ram_data_oe,
   input  logic [`VRAM_DATA_W-1:0] ram_rdata
);

   logic                    write_slot;
   logic [`VRAM_ADDR_W-1:0] addr_sel;
   logic [`VRAM_DATA_W-1:0] wdata_s1;
   logic [`VRAM_DATA_W-1:0] wdata_s2;
   logic                    oe_s2;

   // a write is made only in a cycle without a read
   assign write_slot = !read_req;
   assign addr_sel   = write_slot ? write_addr : read_addr;

   ////////////////////////////////////////
   // address and control, pins at t+1
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ram_address <= '0;
         ram_we_b    <= 1'b1;
         ram_cen_b   <= 1'b1;
      end else begin
         ram_address <= addr_sel;
         ram_we_b    <= !write_slot;
         // clock enable held on once out of reset
         ram_cen_b   <= 1'b0;
      end
   end

   ////////////////////////////////////////
   // late-write data, pins at t+3
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      wdata_s1  <= write_data;
      wdata_s2  <= wdata_s1;
      ram_wdata <= wdata_s2;
   end

   // output enable follows the write strobe two cycles later
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         oe_s2       <= 1'b0;
         ram_data_oe <= 1'b0;
      end else begin
         oe_s2       <= !ram_we_b;
         ram_data_oe <= oe_s2;
      end
   end

   // read word returns at t+3 with no extra stage
   assign read_data = ram_rdata;

endmodule

// File: design/bar_pattern_writer.sv
////////////////////////////////////////
// test-bar writer, free-running address and bar word
////////////////////////////////////////
`timescale 1ns/1ps
`include "xvga_defs.svh"

module bar_pattern_writer (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    bar_period,
   output logic [`VRAM_ADDR_W-1:0] write_addr,
   output logic [`VRAM_DATA_W-1:0] write_data
);
   import vram_pkg::*;

   logic [31:0] count;
   logic [3:0]  bar_field;
   vram_word_u  bar_word;

   // runs every clock, whether or not the write gets its slot
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
      end else begin
         count <= count + 1'b1;
      end
   end

   // narrow bars on bits 6..3, wide bars on bits 7..4
   assign bar_field = bar_period ? count[6:3] : count[7:4];

   // same grey level in all four pixels, low nibble zero
   always_comb begin
      bar_word.pix.unused = 4'h0;
      for (int i = 0; i < 4; i++) begin
         bar_word.pix.px[i] = {bar_field, 4'h0};
      end
   end

   assign write_addr = count[`VRAM_ADDR_W-1:0];
   assign write_data = bar_word.raw;

endmodule

// File: design/video_scanout.sv
////////////////////////////////////////
// frame buffer scan-out with 8 pixel look-ahead
// word latch, byte unpack and registered video out
////////////////////////////////////////
`timescale 1ns/1ps
`include "xvga_defs.svh"

module video_scanout (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [`HCOUNT_W-1:0]    hcount,
   input  logic [`VCOUNT_W-1:0]    vcount,
   input  logic                    hsync,
   input  logic                    vsync,
   input  logic                    blank,
   input  logic                    hw_bars,
   input  logic [`VRAM_DATA_W-1:0] read_data,
   output logic [`VRAM_ADDR_W-1:0] read_addr,
   output logic                    read_req,
   output vram_pkg::pixel_t        pixel,
   output logic                    hsync_out,
   output logic                    vsync_out,
   output logic                    blank_out
);
   import vram_pkg::*;

   // look-ahead wraps at this raster's own line length minus the lead
   localparam logic [`HCOUNT_W-1:0] H_WRAP   = `HCOUNT_W'(`H_TOTAL - `FETCH_AHEAD);
   localparam logic [`HCOUNT_W-1:0] H_AHEAD  = `HCOUNT_W'(`FETCH_AHEAD);
   localparam logic [`HCOUNT_W-1:0] H_ACTIVE = `HCOUNT_W'(`H_ACTIVE);
   localparam logic [`VCOUNT_W-1:0] V_LAST   = `VCOUNT_W'(`V_TOTAL - 1);
   localparam logic [`VCOUNT_W-1:0] V_ACTIVE = `VCOUNT_W'(`V_ACTIVE);

   logic                 wrap;
   logic [`HCOUNT_W-1:0] h_ahead;
   logic [`VCOUNT_W-1:0] v_ahead;
   logic [1:0]           hc4;
   vram_word_u           word_latch;
   vram_word_u           word_disp;
   pixel_t               mem_pixel;

   ////////////////////////////////////////
   // look-ahead position and fetch address
   ////////////////////////////////////////
   assign wrap    = (hcount >= H_WRAP);
   assign h_ahead = wrap ? hcount - H_WRAP : hcount + H_AHEAD;
   // past the line end the fetch moves to the next row, row 805 goes to 0
   assign v_ahead = !wrap ? vcount : ((vcount == V_LAST) ? '0 : vcount + 1'b1);

   // word address {0, row, column/4}
   assign read_addr = {1'b0, v_ahead, h_ahead[9:2]};

   // fetch needed while the look-ahead is visible
   // the port is also held for reads over the visible area itself
   assign read_req = ((h_ahead < H_ACTIVE) && (v_ahead < V_ACTIVE)) || !blank;

   ////////////////////////////////////////
   // word latches and byte unpack
   ////////////////////////////////////////
   assign hc4 = hcount[1:0];

   // word for the next group of four arrives at column mod 4 == 1,
   // then moves to the display register at column mod 4 == 3
   always_ff @(posedge clk) begin
      if (hc4 == 2'd1) begin
         word_latch.raw <= read_data;
      end
      if (hc4 == 2'd3) begin
         word_disp <= word_latch;
      end
   end

   // first pixel of the group sits in the top byte
   assign mem_pixel = word_disp.pix.px[2'd3 - hc4];

   ////////////////////////////////////////
   // output register
   ////////////////////////////////////////
   // hardware bars come straight from the pixel counter
   always_ff @(posedge clk) begin
      pixel <= hw_bars ? {hcount[8:6], 5'b0} : mem_pixel;
   end

   // syncs and blank delayed to match the pixel
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hsync_out <= 1'b1;
         vsync_out <= 1'b1;
         blank_out <= 1'b1;
      end else begin
         hsync_out <= hsync;
         vsync_out <= vsync;
         blank_out <= blank;
      end
   end

endmodule

// File: design/xvga_timing.sv
////////////////////////////////////////
// xvga 1024x768 raster generator
// pixel and line counters, registered syncs and blank
////////////////////////////////////////
`timescale 1ns/1ps
`include "xvga_defs.svh"

module xvga_timing (
   input  logic                 clk,
   input  logic                 rst_n,
   output logic [`HCOUNT_W-1:0] hcount,
   output logic [`VCOUNT_W-1:0] vcount,
   output logic                 hsync,
   output logic                 vsync,
   output logic                 blank
);

   // raster points sized to the counters
   localparam logic [`HCOUNT_W-1:0] H_LAST     = `HCOUNT_W'(`H_TOTAL - 1);
   localparam logic [`HCOUNT_W-1:0] H_ACTIVE   = `HCOUNT_W'(`H_ACTIVE);
   localparam logic [`HCOUNT_W-1:0] H_SYNC_ON  = `HCOUNT_W'(`H_SYNC_ON);
   localparam logic [`HCOUNT_W-1:0] H_SYNC_OFF = `HCOUNT_W'(`H_SYNC_OFF);
   localparam logic [`VCOUNT_W-1:0] V_LAST     = `VCOUNT_W'(`V_TOTAL - 1);
   localparam logic [`VCOUNT_W-1:0] V_ACTIVE   = `VCOUNT_W'(`V_ACTIVE);
   localparam logic [`VCOUNT_W-1:0] V_SYNC_ON  = `VCOUNT_W'(`V_SYNC_ON);
   localparam logic [`VCOUNT_W-1:0] V_SYNC_OFF = `VCOUNT_W'(`V_SYNC_OFF);

   logic                 h_last;
   logic                 v_last;
   logic [`HCOUNT_W-1:0] h_next;
   logic [`VCOUNT_W-1:0] v_next;
   logic                 h_blank_next;
   logic                 v_blank_next;

   // wrap points
   assign h_last = (hcount == H_LAST);
   assign v_last = (vcount == V_LAST);

   // next raster position
   // line counter only moves on the last pixel of a line
   assign h_next = h_last ? '0 : hcount + 1'b1;
   assign v_next = !h_last ? vcount : (v_last ? '0 : vcount + 1'b1);

   // blanking of the next position, so blank lines up with the counters
   assign h_blank_next = (h_next >= H_ACTIVE);
   assign v_blank_next = (v_next >= V_ACTIVE);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hcount <= '0;
         vcount <= '0;
         hsync  <= 1'b1;
         vsync  <= 1'b1;
         blank  <= 1'b0;
      end else begin
         hcount <= h_next;
         vcount <= v_next;
         // active low, 136 pixels wide
         hsync  <= !((h_next >= H_SYNC_ON) && (h_next < H_SYNC_OFF));
         // active low, 6 lines tall
         vsync  <= !((v_next >= V_SYNC_ON) && (v_next < V_SYNC_OFF));
         blank  <= h_blank_next || v_blank_next;
      end
   end

endmodule

// File: design/vram_pkg.sv
////////////////////////////////////////
// frame buffer word and grey pixel types
////////////////////////////////////////
`include "xvga_defs.svh"

package vram_pkg;

   // one 8-bit grey level
   typedef logic [7:0] pixel_t;

   // one sram word, seen either as raw bits on the pins
   // or as four packed pixels
   typedef union packed {
      // raw word as the port and the ram pins carry it
      logic [`VRAM_DATA_W-1:0] raw;
      // pixel view
      // px[3] is the first pixel shown, px[0] the last
      // the top nibble carries no pixel data
      struct packed {
         logic [3:0]   unused;
         pixel_t [3:0] px;
      } pix;
   } vram_word_u;

endpackage

// File: design/xvga_defs.svh
////////////////////////////////////////
// xvga raster points, look-ahead distance
// and frame buffer memory widths
////////////////////////////////////////
`ifndef XVGA_DEFS_SVH
`define XVGA_DEFS_SVH

// horizontal raster, in pixel clocks
`define H_ACTIVE     1024
`define H_SYNC_ON    1047
`define H_SYNC_OFF   1183
`define H_TOTAL      1344

// vertical raster, in lines
`define V_ACTIVE     768
`define V_SYNC_ON    776
`define V_SYNC_OFF   782
`define V_TOTAL      806

// scan-out fetches this many pixel times early
// to hide the zbt pipeline and the word latches
`define FETCH_AHEAD  8

// raster counter widths
`define HCOUNT_W     11
`define VCOUNT_W     10

// zbt sram geometry, 512k words of 36 bits
`define VRAM_ADDR_W  19
`define VRAM_DATA_W  36

`endif
